// ==== Makefile ====
VERILATOR := verilator
VFLAGS    := --binary --timing --assert --timescale 1ns/1ps -j 0
TOP       := tb_core
FILELIST  := src.f
OBJ_DIR   := obj_dir
BIN       := $(OBJ_DIR)/V$(TOP)
SRCS      := $(shell grep -v '^+' $(FILELIST)) hdl/core_cfg.svh
PASS_MSG  := sim passed

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== hdl/core_cfg.svh ====
`ifndef CORE_CFG_SVH
`define CORE_CFG_SVH

// data path and address width
`define CORE_XLEN 64

// instruction memory depth in 32-bit words
`define CORE_IMEM_WORDS 256

// data memory depth in doublewords
`define CORE_DMEM_WORDS 256

`define CORE_NREGS 32

`endif

// ==== hdl/core_pkg.sv ====
`include "core_cfg.svh"

package core_pkg;

  typedef logic [`CORE_XLEN-1:0] xlen_t;
  typedef logic [$clog2(`CORE_NREGS)-1:0] reg_idx_t;

  // major opcodes handled by decode
  typedef enum logic [6:0] {
    OPC_LOAD   = 7'b0000011,
    OPC_OP_IMM = 7'b0010011,
    OPC_STORE  = 7'b0100011,
    OPC_OP     = 7'b0110011,
    OPC_LUI    = 7'b0110111,
    OPC_BRANCH = 7'b1100011
  } opcode_e;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLL,
    ALU_SRL,
    ALU_SRA,
    ALU_SLT,
    ALU_PASS_B
  } alu_op_e;

  // every stage payload starts with valid, pipe_reg relies on a cleared word being a bubble
  typedef struct packed {
    logic        valid;
    xlen_t       pc;
    logic [31:0] instr;
  } if_id_t;

  typedef struct packed {
    logic     valid;
    xlen_t    pc;
    alu_op_e  alu_op;
    reg_idx_t rs1;
    reg_idx_t rs2;
    reg_idx_t rd;
    xlen_t    rs1_val;
    xlen_t    rs2_val;
    xlen_t    imm;
    logic     use_imm;
    logic     is_load;
    logic     is_store;
    logic     is_branch;
    logic     branch_ne;
    logic     writes_rd;
  } id_ex_t;

  typedef struct packed {
    logic     valid;
    xlen_t    pc;
    xlen_t    result;
    xlen_t    store_data;
    reg_idx_t rd;
    logic     is_load;
    logic     is_store;
    logic     writes_rd;
  } ex_mem_t;

  typedef struct packed {
    logic     valid;
    xlen_t    pc;
    xlen_t    result;
    reg_idx_t rd;
    logic     writes_rd;
  } mem_wb_t;

  typedef struct packed {
    xlen_t    pc;
    reg_idx_t rd;
    xlen_t    data;
  } retire_t;

  // a result travelling back toward execute or decode
  typedef struct packed {
    logic     we;
    reg_idx_t rd;
    xlen_t    value;
  } fwd_t;

endpackage

// ==== hdl/decode_stage.sv ====
`include "core_cfg.svh"

module decode_stage (
  input  logic              clk,
  input  logic              reset,
  input  core_pkg::if_id_t  in,
  input  core_pkg::mem_wb_t wb,
  input  logic [4:0]        ex_load_rd,
  input  logic              ex_is_load,
  output core_pkg::id_ex_t  out,
  output logic              stall
);

  import core_pkg::*;

  logic [`CORE_XLEN-1:0] regs [`CORE_NREGS];
  opcode_e               opcode;
  logic [2:0]            funct3;
  logic [6:0]            funct7;
  logic                  uses_rs1;
  logic                  uses_rs2;
  reg_idx_t              rs1;
  reg_idx_t              rs2;
  reg_idx_t              rd;
  logic                  wb_we;
  xlen_t                 rs1_val;
  xlen_t                 rs2_val;
  xlen_t                 imm_i;
  xlen_t                 imm_s;
  xlen_t                 imm_b;
  xlen_t                 imm_u;

  assign opcode = opcode_e'(in.instr[6:0]);
  assign funct3 = in.instr[14:12];
  assign funct7 = in.instr[31:25];
  assign rd     = in.instr[11:7];

  // unused source fields are zeroed so they never match a hazard or a forward
  assign uses_rs1 = (opcode != OPC_LUI);
  assign uses_rs2 = (opcode == OPC_OP) || (opcode == OPC_STORE) || (opcode == OPC_BRANCH);
  assign rs1      = uses_rs1 ? in.instr[19:15] : '0;
  assign rs2      = uses_rs2 ? in.instr[24:20] : '0;

  assign imm_i = {{(`CORE_XLEN-12){in.instr[31]}}, in.instr[31:20]};
  assign imm_s = {{(`CORE_XLEN-12){in.instr[31]}}, in.instr[31:25], in.instr[11:7]};
  assign imm_b = {{(`CORE_XLEN-13){in.instr[31]}}, in.instr[31], in.instr[7],
                  in.instr[30:25], in.instr[11:8], 1'b0};
  assign imm_u = {{(`CORE_XLEN-32){in.instr[31]}}, in.instr[31:12], 12'b0};

  // a write landing this cycle is seen by the register read straight away
  assign wb_we   = wb.valid && wb.writes_rd && (wb.rd != '0);
  assign rs1_val = (rs1 == '0) ? '0 : (wb_we && wb.rd == rs1) ? wb.result : regs[rs1];
  assign rs2_val = (rs2 == '0) ? '0 : (wb_we && wb.rd == rs2) ? wb.result : regs[rs2];

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < `CORE_NREGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wb_we) begin
      regs[wb.rd] <= wb.result;
    end
  end

  always_comb begin
    out         = '0;
    out.valid   = in.valid;
    out.pc      = in.pc;
    out.rs1     = rs1;
    out.rs2     = rs2;
    out.rd      = rd;
    out.rs1_val = rs1_val;
    out.rs2_val = rs2_val;
    out.alu_op  = ALU_ADD;
    case (opcode)
      OPC_OP: begin
        out.writes_rd = (rd != '0);
        case (funct3)
          3'b000:  out.alu_op = funct7[5] ? ALU_SUB : ALU_ADD;
          3'b001:  out.alu_op = ALU_SLL;
          3'b010:  out.alu_op = ALU_SLT;
          3'b100:  out.alu_op = ALU_XOR;
          3'b101:  out.alu_op = funct7[5] ? ALU_SRA : ALU_SRL;
          3'b110:  out.alu_op = ALU_OR;
          default: out.alu_op = ALU_AND;
        endcase
      end
      OPC_OP_IMM: begin
        out.use_imm   = 1'b1;
        out.imm       = imm_i;
        out.writes_rd = (rd != '0);
        case (funct3)
          3'b100:  out.alu_op = ALU_XOR;
          3'b110:  out.alu_op = ALU_OR;
          3'b111:  out.alu_op = ALU_AND;
          default: out.alu_op = ALU_ADD;
        endcase
      end
      OPC_LUI: begin
        out.use_imm   = 1'b1;
        out.imm       = imm_u;
        out.alu_op    = ALU_PASS_B;
        out.writes_rd = (rd != '0);
      end
      OPC_LOAD: begin
        out.use_imm   = 1'b1;
        out.imm       = imm_i;
        out.is_load   = 1'b1;
        out.writes_rd = (rd != '0);
      end
      OPC_STORE: begin
        out.use_imm  = 1'b1;
        out.imm      = imm_s;
        out.is_store = 1'b1;
      end
      OPC_BRANCH: begin
        out.imm       = imm_b;
        out.is_branch = 1'b1;
        out.branch_ne = funct3[0];
      end
      // bubbles and unsupported words
      default: out.valid = 1'b0;
    endcase
  end

  // hold one cycle when the load in execute feeds a source here
  assign stall = in.valid && ex_is_load && (ex_load_rd != '0) &&
                 ((ex_load_rd == rs1) || (ex_load_rd == rs2));

  // the bubble sent into execute clears a load-use hazard after one cycle
  a_stall_one_cycle: assert property (
    @(posedge clk) disable iff (reset)
    stall |=> !stall
  );

endmodule

// ==== hdl/execute_stage.sv ====
`include "core_cfg.svh"

module execute_stage (
  input  core_pkg::id_ex_t      in,
  input  core_pkg::fwd_t        fwd_mem,
  input  core_pkg::fwd_t        fwd_wb,
  output core_pkg::ex_mem_t     out,
  output logic                  redirect,
  output logic [`CORE_XLEN-1:0] redirect_pc
);

  import core_pkg::*;

  xlen_t      op_a;
  xlen_t      rs2_fwd;
  xlen_t      op_b;
  xlen_t      alu_res;
  logic [5:0] shamt;
  logic       taken;

  // youngest producer wins, memory stage before writeback
  function automatic xlen_t fwd_pick(
    input reg_idx_t idx,
    input xlen_t    reg_val,
    input fwd_t     m,
    input fwd_t     w
  );
    if (idx != '0 && m.we && m.rd == idx) begin
      return m.value;
    end
    if (idx != '0 && w.we && w.rd == idx) begin
      return w.value;
    end
    return reg_val;
  endfunction

  assign op_a    = fwd_pick(in.rs1, in.rs1_val, fwd_mem, fwd_wb);
  assign rs2_fwd = fwd_pick(in.rs2, in.rs2_val, fwd_mem, fwd_wb);
  assign op_b    = in.use_imm ? in.imm : rs2_fwd;
  assign shamt   = op_b[5:0];

  always_comb begin
    case (in.alu_op)
      ALU_ADD:    alu_res = op_a + op_b;
      ALU_SUB:    alu_res = op_a - op_b;
      ALU_AND:    alu_res = op_a & op_b;
      ALU_OR:     alu_res = op_a | op_b;
      ALU_XOR:    alu_res = op_a ^ op_b;
      ALU_SLL:    alu_res = op_a << shamt;
      ALU_SRL:    alu_res = op_a >> shamt;
      ALU_SRA:    alu_res = $signed(op_a) >>> shamt;
      ALU_SLT:    alu_res = {{(`CORE_XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
      ALU_PASS_B: alu_res = op_b;
      default:    alu_res = '0;
    endcase
  end

  // beq and bne compare the forwarded register values
  assign taken       = (op_a == rs2_fwd) != in.branch_ne;
  assign redirect    = in.valid && in.is_branch && taken;
  assign redirect_pc = in.pc + in.imm;

  always_comb begin
    out.valid      = in.valid;
    out.pc         = in.pc;
    out.result     = alu_res;
    out.store_data = rs2_fwd;
    out.rd         = in.rd;
    out.is_load    = in.is_load;
    out.is_store   = in.is_store;
    out.writes_rd  = in.writes_rd;
  end

endmodule

// ==== hdl/fetch_stage.sv ====
`include "core_cfg.svh"

module fetch_stage (
  input  logic                                clk,
  input  logic                                reset,
  input  logic [`CORE_XLEN-1:0]               entry,
  input  logic                                stall,
  input  logic                                redirect,
  input  logic [`CORE_XLEN-1:0]               redirect_pc,
  input  logic                                prog_we,
  input  logic [$clog2(`CORE_IMEM_WORDS)-1:0] prog_addr,
  input  logic [31:0]                         prog_data,
  output core_pkg::if_id_t                    out
);

  localparam int IDX_W = $clog2(`CORE_IMEM_WORDS);

  logic [31:0]           imem [`CORE_IMEM_WORDS];
  logic [`CORE_XLEN-1:0] pc;

  // program load only while the core sits in reset
  always_ff @(posedge clk) begin
    if (reset && prog_we) begin
      imem[prog_addr] <= prog_data;
    end
  end

  // redirect from execute beats the load-use hold
  always_ff @(posedge clk) begin
    if (reset) begin
      pc <= entry;
    end else if (redirect) begin
      pc <= redirect_pc;
    end else if (!stall) begin
      pc <= pc + `CORE_XLEN'(4);
    end
  end

  // always valid, the fetch/decode register is cleared in reset anyway
  always_comb begin
    out.valid = 1'b1;
    out.pc    = pc;
    out.instr = imem[pc[IDX_W+1:2]];
  end

  a_pc_aligned: assert property (
    @(posedge clk) disable iff (reset)
    pc[1:0] == 2'b00
  );

endmodule

// ==== hdl/memory_stage.sv ====
`include "core_cfg.svh"

module memory_stage (
  input  logic              clk,
  input  logic              reset,
  input  core_pkg::ex_mem_t in,
  output core_pkg::mem_wb_t out,
  output core_pkg::fwd_t    fwd
);

  localparam int IDX_W = $clog2(`CORE_DMEM_WORDS);

  logic [`CORE_XLEN-1:0] dmem [`CORE_DMEM_WORDS];
  logic [IDX_W-1:0]      idx;
  logic [`CORE_XLEN-1:0] load_data;

  // doubleword index, the low three address bits are zero
  assign idx       = in.result[IDX_W+2:3];
  assign load_data = dmem[idx];

  always_ff @(posedge clk) begin
    if (!reset && in.valid && in.is_store) begin
      dmem[idx] <= in.store_data;
    end
  end

  always_comb begin
    out.valid     = in.valid;
    out.pc        = in.pc;
    out.result    = in.is_load ? load_data : in.result;
    out.rd        = in.rd;
    out.writes_rd = in.writes_rd;
  end

  // load data is already here, so a load one ahead forwards cleanly
  always_comb begin
    fwd.we    = in.valid && in.writes_rd;
    fwd.rd    = in.rd;
    fwd.value = out.result;
  end

  a_dword_aligned: assert property (
    @(posedge clk) disable iff (reset)
    in.valid && (in.is_load || in.is_store) |-> in.result[2:0] == 3'b000
  );

endmodule

// ==== hdl/pipe_reg.sv ====
module pipe_reg #(
  parameter type payload_t = logic
) (
  input  logic     clk,
  input  logic     reset,
  input  logic     stall,
  input  logic     flush,
  input  payload_t d,
  output payload_t q
);

  // flush beats stall so a squashed slot never survives a hold
  always_ff @(posedge clk) begin
    if (reset || flush) begin
      q <= '0;
    end else if (!stall) begin
      q <= d;
    end
  end

endmodule

// ==== hdl/riscv_core.sv ====
`include "core_cfg.svh"

module riscv_core (
  input  logic                                clk,
  input  logic                                reset,
  input  logic [`CORE_XLEN-1:0]               entry,
  input  logic                                prog_we,
  input  logic [$clog2(`CORE_IMEM_WORDS)-1:0] prog_addr,
  input  logic [31:0]                         prog_data,
  output logic                                retire,
  output core_pkg::retire_t                   retire_info
);

  import core_pkg::*;

  if_id_t  f_out;
  if_id_t  d_in;
  id_ex_t  d_out;
  id_ex_t  e_in;
  ex_mem_t e_out;
  ex_mem_t m_in;
  mem_wb_t m_out;
  mem_wb_t wb;
  fwd_t    fwd_mem;
  fwd_t    fwd_wb;
  logic    stall;
  logic    redirect;
  xlen_t   redirect_pc;

  fetch_stage u_fetch (
    .clk(clk), .reset(reset), .entry(entry),
    .stall(stall), .redirect(redirect), .redirect_pc(redirect_pc),
    .prog_we(prog_we), .prog_addr(prog_addr), .prog_data(prog_data),
    .out(f_out)
  );

  pipe_reg #(.payload_t(if_id_t)) u_if_id (
    .clk(clk), .reset(reset), .stall(stall), .flush(redirect), .d(f_out), .q(d_in)
  );

  decode_stage u_decode (
    .clk(clk), .reset(reset), .in(d_in), .wb(wb),
    .ex_load_rd(e_in.rd), .ex_is_load(e_in.valid && e_in.is_load),
    .out(d_out), .stall(stall)
  );

  // a load-use hold sends a bubble into execute
  pipe_reg #(.payload_t(id_ex_t)) u_id_ex (
    .clk(clk), .reset(reset), .stall(1'b0), .flush(redirect || stall), .d(d_out), .q(e_in)
  );

  execute_stage u_execute (
    .in(e_in), .fwd_mem(fwd_mem), .fwd_wb(fwd_wb),
    .out(e_out), .redirect(redirect), .redirect_pc(redirect_pc)
  );

  pipe_reg #(.payload_t(ex_mem_t)) u_ex_mem (
    .clk(clk), .reset(reset), .stall(1'b0), .flush(1'b0), .d(e_out), .q(m_in)
  );

  memory_stage u_memory (
    .clk(clk), .reset(reset), .in(m_in), .out(m_out), .fwd(fwd_mem)
  );

  pipe_reg #(.payload_t(mem_wb_t)) u_mem_wb (
    .clk(clk), .reset(reset), .stall(1'b0), .flush(1'b0), .d(m_out), .q(wb)
  );

  assign fwd_wb.we    = wb.valid && wb.writes_rd;
  assign fwd_wb.rd    = wb.rd;
  assign fwd_wb.value = wb.result;

  // stores, branches and x0 targets retire with rd and data zero
  assign retire           = wb.valid;
  assign retire_info.pc   = wb.pc;
  assign retire_info.rd   = wb.writes_rd ? wb.rd : '0;
  assign retire_info.data = wb.writes_rd ? wb.result : '0;

endmodule

// ==== src.f ====
+incdir+hdl
hdl/core_pkg.sv
hdl/pipe_reg.sv
hdl/fetch_stage.sv
hdl/decode_stage.sv
hdl/execute_stage.sv
hdl/memory_stage.sv
hdl/riscv_core.sv
tests/tb_core.sv

// ==== tests/program_input.txt ====
// header: entry pc, program word count, expected record count
100 1f 1b
// program words in hex, loaded from the entry word on
05a00093 // 100 addi x1, x0, 90
ffd00113 // 104 addi x2, x0, -3
002081b3 // 108 add  x3, x1, x2
40110233 // 10c sub  x4, x2, x1
0041f2b3 // 110 and  x5, x3, x4
0041e333 // 114 or   x6, x3, x4
0041c3b3 // 118 xor  x7, x3, x4
00509433 // 11c sll  x8, x1, x5
005154b3 // 120 srl  x9, x2, x5
40515533 // 124 sra  x10, x2, x5
001125b3 // 128 slt  x11, x2, x1
0020a633 // 12c slt  x12, x1, x2
00f0f693 // 130 andi x13, x1, 15
f000e713 // 134 ori  x14, x1, -256
7ff14793 // 138 xori x15, x2, 2047
80000837 // 13c lui  x16, 0x80000
123458b7 // 140 lui  x17, 0x12345
04603023 // 144 sd   x6, 64(x0)
04003903 // 148 ld   x18, 64(x0)
001909b3 // 14c add  x19, x18, x1
00708013 // 150 addi x0, x1, 7
00100a33 // 154 add  x20, x0, x1
00308463 // 158 beq  x1, x3, 8 not taken
00109463 // 15c bne  x1, x1, 8 not taken
00b58663 // 160 beq  x11, x11, 12 taken
00100a93 // 164 addi x21, x0, 1 skipped
00200b13 // 168 addi x22, x0, 2 skipped
00209663 // 16c bne  x1, x2, 12 taken
00300b93 // 170 addi x23, x0, 3 skipped
00400c13 // 174 addi x24, x0, 4 skipped
013a0cb3 // 178 add  x25, x20, x19
// expected retire records, one per line: pc rd data
100 01 000000000000005a
104 02 fffffffffffffffd
108 03 0000000000000057
10c 04 ffffffffffffffa3
110 05 0000000000000003
114 06 fffffffffffffff7
118 07 fffffffffffffff4
11c 08 00000000000002d0
120 09 1fffffffffffffff
124 0a ffffffffffffffff
128 0b 0000000000000001
12c 0c 0000000000000000
130 0d 000000000000000a
134 0e ffffffffffffff5a
138 0f fffffffffffff802
13c 10 ffffffff80000000
140 11 0000000012345000
144 00 0000000000000000
148 12 fffffffffffffff7
14c 13 0000000000000051
150 00 0000000000000000
154 14 000000000000005a
158 00 0000000000000000
15c 00 0000000000000000
160 00 0000000000000000
16c 00 0000000000000000
178 19 00000000000000ab

// ==== tests/tb_core.sv ====
`include "core_cfg.svh"

module tb_core;
  timeunit 1ns;
  timeprecision 1ps;

  import core_pkg::*;

  localparam int IMEM_IDX_W   = $clog2(`CORE_IMEM_WORDS);
  localparam int DRAIN_CYCLES = 20;

  logic                  clk;
  logic                  reset;
  logic [`CORE_XLEN-1:0] entry;
  logic                  prog_we;
  logic [IMEM_IDX_W-1:0] prog_addr;
  logic [31:0]           prog_data;
  logic                  retire;
  retire_t               retire_info;

  // raw words of the input file: header, program, then records
  logic [63:0] stim [512];
  retire_t     expected_q [$];
  int          n_prog;
  int          n_exp;
  int          retired = 0;
  int          check_errors = 0;
  int          setup_errors;
  bit          loaded;

  riscv_core u_riscv_core (
    .clk(clk), .reset(reset), .entry(entry),
    .prog_we(prog_we), .prog_addr(prog_addr), .prog_data(prog_data),
    .retire(retire), .retire_info(retire_info)
  );

  initial clk = 1'b0;
  always #10 clk = ~clk;

  function automatic logic [63:0] stim_word(input int idx);
    return stim[idx[8:0]];
  endfunction

  task automatic read_expected();
    retire_t     rec;
    logic [63:0] rd_word;
    int          base;
    for (int i = 0; i < n_exp; i++) begin
      base     = 3 + n_prog + 3 * i;
      rd_word  = stim_word(base + 1);
      rec.pc   = stim_word(base);
      rec.rd   = rd_word[4:0];
      rec.data = stim_word(base + 2);
      expected_q.push_back(rec);
    end
  endtask

  // program words go in from the entry word on, one per cycle
  task automatic load_program();
    logic [63:0] word;
    logic [63:0] base_idx;
    base_idx = stim_word(0) >> 2;
    for (int i = 0; i < n_prog; i++) begin
      word = stim_word(3 + i);
      @(posedge clk);
      #1;
      prog_we   = 1'b1;
      prog_addr = IMEM_IDX_W'(base_idx + 64'(i));
      prog_data = word[31:0];
    end
    @(posedge clk);
    #1;
    prog_we = 1'b0;
  endtask

  task automatic check_retire(input retire_t got);
    retire_t exp;
    if (retired >= expected_q.size()) begin
      $display("ERROR at %0t: retire of pc %h came after all %0d expected records were seen",
               $time, got.pc, expected_q.size());
      check_errors++;
    end else begin
      exp = expected_q[retired];
      if (got.pc !== exp.pc) begin
        $display("MISMATCH at %0t: retire_info.pc got %h expected %h", $time, got.pc, exp.pc);
        check_errors++;
      end
      if (got.rd !== exp.rd) begin
        $display("MISMATCH at %0t: retire_info.rd got %0d expected %0d",
                 $time, got.rd, exp.rd);
        check_errors++;
      end
      if (got.data !== exp.data) begin
        $display("MISMATCH at %0t: retire_info.data got %h expected %h",
                 $time, got.data, exp.data);
        check_errors++;
      end
    end
    retired++;
  endtask

  // retire changes on the rising edge, so look at it on the falling one
  always @(negedge clk) begin
    if (!reset && retire) begin
      check_retire(retire_info);
    end
  end

  initial begin
    reset        = 1'b1;
    entry        = '0;
    prog_we      = 1'b0;
    prog_addr    = '0;
    prog_data    = '0;
    setup_errors = 0;
    $readmemh("tests/program_input.txt", stim);
    n_prog = int'(stim_word(1));
    n_exp  = int'(stim_word(2));
    if (n_prog == 0 || n_exp == 0) begin
      $display("ERROR: the input file holds no program words or no expected records");
      setup_errors++;
    end else begin
      read_expected();
      loaded = 1'b1;
      load_program();
      entry = stim_word(0);
      // fetch takes entry on each reset edge
      repeat (5) @(posedge clk);
      #1;
      reset = 1'b0;
      wait (retired >= n_exp);
      // extra retires after the last record still get caught
      repeat (DRAIN_CYCLES) @(posedge clk);
    end
    $display("errors: %0d, retired %0d of %0d expected",
             check_errors + setup_errors, retired, n_exp);
    if (check_errors + setup_errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

  initial begin : watchdog
    int limit;
    wait (loaded);
    limit = 40 * n_exp + n_prog + 10;
    repeat (limit) @(posedge clk);
    $display("ERROR: timeout after %0d cycles, %0d of %0d expected records never retired",
             limit, n_exp - retired, n_exp);
    $display("errors: %0d, retired %0d of %0d expected",
             check_errors + setup_errors + 1, retired, n_exp);
    $display("sim failed");
    $finish;
  end

endmodule
